//--- rtl/mem_pkg.sv
// 16-bit aligned words only; address bit 0 ignored; MEM_LATENCY must be at least 1
package mem_pkg;

    ////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] word_t;      // Data word or byte address
    typedef logic [3:0]  reg_idx_t;   // Register file index
    typedef logic [7:0]  word_idx_t;  // Word index into data memory

    ////////////////////////////////////////////////////////////
    // Memory system
    ////////////////////////////////////////////////////////////

    localparam int MEM_WORDS   = 256;  // Words in data memory
    localparam int MEM_LATENCY = 4;    // Accept to response, in cycles

    // Response countdown, wide enough for MEM_LATENCY
    typedef logic [$clog2(MEM_LATENCY + 1) - 1:0] lat_cnt_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;  // AXI OKAY response

    ////////////////////////////////////////////////////////////
    // Stack pointer
    ////////////////////////////////////////////////////////////

    localparam word_t SP_STEP = 16'd2;  // Bytes moved by call and ret

    // Memory stage bus sequencer
    typedef enum logic [1:0] {
        IDLE,  // No request, ops may pass
        ADDR,  // Address and write data phase
        RESP   // Waiting on B or R
    } axi_state_t;

endpackage

//--- rtl/mem_unit.sv
// Execute side holds inputs steady while stall is high; a set mem_write takes priority over mem_read
`timescale 1ns/100ps

module mem_unit import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Execute side
    input  logic       ex_valid,
    input  logic       call,
    input  logic       reg_write,
    input  logic       mem_write,
    input  logic       mem_read,
    input  logic       mem_to_reg,
    input  reg_idx_t   reg_rd,
    input  word_t      alu_result,
    input  word_t      store_data,   // PC during call
    input  logic       ret_future,
    input  logic       halt,
    output logic       stall,
    // AXI4-Lite master
    output word_t      awaddr,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output logic       wvalid,
    input  logic       wready,
    input  logic [1:0] bresp,
    input  logic       bvalid,
    output logic       bready,
    output word_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic [1:0] rresp,
    input  logic       rvalid,
    output logic       rready,
    // Toward writeback
    output logic       mw_valid,
    output logic       mw_reg_write,
    output logic       mw_mem_to_reg,
    output reg_idx_t   mw_reg_rd,
    output word_t      mw_alu_result,
    output word_t      mw_read_data,
    output logic       mw_ret_future,
    output logic       mw_halt
);

    axi_state_t state, state_nxt;
    word_t      mem_addr;
    logic       mem_op, is_store;
    logic       aw_done, w_done;  // Channel already transferred this op
    logic       aw_fire, w_fire, ar_fire, resp_fire, resp_ok;

    ////////////////////////////////////////////////////////////
    // Stack pointer muxes
    ////////////////////////////////////////////////////////////

    assign mem_addr      = ret_future ? alu_result + SP_STEP : alu_result;  // Ret pops above SP
    assign mw_alu_result = call ? alu_result - SP_STEP : alu_result;        // Call pushes below

    assign mem_op   = mem_write | mem_read;
    assign is_store = mem_write;

    ////////////////////////////////////////////////////////////
    // Bus signals
    ////////////////////////////////////////////////////////////

    assign awaddr  = mem_addr;
    assign araddr  = mem_addr;
    assign wdata   = store_data;
    assign awvalid = (state == ADDR) && is_store && !aw_done;
    assign wvalid  = (state == ADDR) && is_store && !w_done;
    assign arvalid = (state == ADDR) && !is_store;
    assign bready  = (state == RESP) && is_store;
    assign rready  = (state == RESP) && !is_store;

    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign ar_fire   = arvalid && arready;
    assign resp_fire = (bvalid && bready) || (rvalid && rready);
    assign resp_ok   = is_store ? (bresp == RESP_OKAY) : (rresp == RESP_OKAY);

    // Sequencer
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (ex_valid && mem_op) state_nxt = ADDR;
            ADDR: begin
                if (is_store) begin
                    if ((aw_done || aw_fire) && (w_done || w_fire))
                        state_nxt = RESP;  // Both AW and W gone
                end else if (ar_fire) begin
                    state_nxt = RESP;
                end
            end
            RESP: if (resp_fire) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state != ADDR) begin  // Flags only live in ADDR
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                aw_done <= aw_done | aw_fire;
                w_done  <= w_done | w_fire;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stall and pipe to pipe
    ////////////////////////////////////////////////////////////

    // Memory op stalls from first cycle until its response lands
    assign stall    = (state == IDLE) ? (ex_valid && mem_op) : !resp_fire;
    assign mw_valid = ex_valid && ((state == IDLE) ? !mem_op : resp_fire);

    // Faulting access leaves the register file alone
    assign mw_reg_write  = reg_write && (!mem_op || resp_ok);
    assign mw_mem_to_reg = mem_to_reg;
    assign mw_reg_rd     = reg_rd;
    assign mw_read_data  = rdata;  // Held by memory until R transfer
    assign mw_ret_future = ret_future;
    assign mw_halt       = halt;

endmodule

//--- rtl/data_memory.sv
// One request at a time, response exactly MEM_LATENCY cycles after accept; contents survive reset
`timescale 1ns/100ps

module data_memory import mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Write address and data
    input  word_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  word_t      wdata,
    input  logic       wvalid,
    output logic       wready,
    // Write response
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    // Read address and data
    input  word_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);

    word_t     mem [MEM_WORDS];  // Word organized storage
    logic      pending;          // Request accepted, response not yet taken
    logic      pend_write;       // Pending op is a store
    lat_cnt_t  cnt;              // Cycles left until response
    logic      wr_acc, rd_acc;
    word_idx_t wr_idx, rd_idx;

    ////////////////////////////////////////////////////////////
    // Request acceptance
    ////////////////////////////////////////////////////////////

    // Store needs AW and W together; store wins over load
    assign wr_acc = !pending && awvalid && wvalid;
    assign rd_acc = !pending && arvalid && !wr_acc;

    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = rd_acc;

    assign wr_idx = awaddr[8:1];  // Byte address to word index
    assign rd_idx = araddr[8:1];

    ////////////////////////////////////////////////////////////
    // Response timing
    ////////////////////////////////////////////////////////////

    assign bvalid = pending && pend_write && (cnt == '0);
    assign rvalid = pending && !pend_write && (cnt == '0);
    assign bresp  = RESP_OKAY;  // No error responses
    assign rresp  = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            pend_write <= 1'b0;
            cnt        <= '0;
        end else if (wr_acc || rd_acc) begin
            pending    <= 1'b1;
            pend_write <= wr_acc;
            cnt        <= lat_cnt_t'(MEM_LATENCY - 1);  // Count from the cycle after accept
        end else if (pending) begin
            if (cnt != '0)
                cnt <= cnt - 1'b1;
            else if ((bvalid && bready) || (rvalid && rready))
                pending <= 1'b0;  // Response taken, free again
        end
    end

    // Array and read data, no reset
    always_ff @(posedge clk) begin
        if (wr_acc)
            mem[wr_idx] <= wdata;  // Write lands on accept
        if (rd_acc)
            rdata <= mem[rd_idx];  // Held until R transfer
    end

endmodule

//--- rtl/mem_wb_stage.sv
// No back-pressure; halted clears only on reset
`timescale 1ns/100ps

module mem_wb_stage import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // From memory stage
    input  logic     mw_valid,
    input  logic     mw_reg_write,
    input  logic     mw_mem_to_reg,
    input  reg_idx_t mw_reg_rd,
    input  word_t    mw_alu_result,
    input  word_t    mw_read_data,
    input  logic     mw_ret_future,
    input  logic     mw_halt,
    // To register file
    output logic     wb_valid,
    output logic     wb_reg_write,
    output reg_idx_t wb_reg_rd,
    output word_t    wb_data,
    output logic     wb_ret_future,
    output logic     halted
);

    ////////////////////////////////////////////////////////////
    // Control, cleared on reset
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            halted       <= 1'b0;
        end else begin
            wb_valid     <= mw_valid;
            wb_reg_write <= mw_valid && mw_reg_write;  // No stale writes between ops
            if (mw_valid && mw_halt)
                halted <= 1'b1;  // Sticky
        end
    end

    // Payload, loaded per strobe
    always_ff @(posedge clk) begin
        if (mw_valid) begin
            wb_reg_rd     <= mw_reg_rd;
            wb_ret_future <= mw_ret_future;
            wb_data       <= mw_mem_to_reg ? mw_read_data : mw_alu_result;  // WB mux
        end
    end

endmodule

//--- rtl/mem_subsystem.sv
// Execute side must hold its inputs while stall is high
`timescale 1ns/100ps

module mem_subsystem import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // Execute side
    input  logic     ex_valid,
    input  logic     call,
    input  logic     reg_write,
    input  logic     mem_write,
    input  logic     mem_read,
    input  logic     mem_to_reg,
    input  reg_idx_t reg_rd,
    input  word_t    alu_result,
    input  word_t    store_data,
    input  logic     ret_future,
    input  logic     halt,
    output logic     stall,
    // Writeback
    output logic     wb_valid,
    output logic     wb_reg_write,
    output reg_idx_t wb_reg_rd,
    output word_t    wb_data,
    output logic     wb_ret_future,
    output logic     halted
);

    // AXI4-Lite link
    word_t      awaddr, wdata, araddr, rdata;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;

    // MEM/WB link
    logic       mw_valid, mw_reg_write, mw_mem_to_reg, mw_ret_future, mw_halt;
    reg_idx_t   mw_reg_rd;
    word_t      mw_alu_result, mw_read_data;

    mem_unit u_mem_unit (
        .clk, .rst,
        .ex_valid, .call, .reg_write, .mem_write, .mem_read, .mem_to_reg,
        .reg_rd, .alu_result, .store_data, .ret_future, .halt, .stall,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .mw_valid, .mw_reg_write, .mw_mem_to_reg, .mw_reg_rd,
        .mw_alu_result, .mw_read_data, .mw_ret_future, .mw_halt
    );

    data_memory u_data_memory (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    mem_wb_stage u_mem_wb_stage (
        .clk, .rst,
        .mw_valid, .mw_reg_write, .mw_mem_to_reg, .mw_reg_rd,
        .mw_alu_result, .mw_read_data, .mw_ret_future, .mw_halt,
        .wb_valid, .wb_reg_write, .wb_reg_rd, .wb_data, .wb_ret_future, .halted
    );

endmodule

//--- test/mem_subsystem_asserts.sv
// Bound into mem_unit; valid hold, stall while busy, quiet bus after reset
`timescale 1ns/100ps

module mem_subsystem_asserts import mem_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       stall,
    input axi_state_t state,
    input word_t      awaddr,
    input word_t      wdata,
    input word_t      araddr,
    input logic       awvalid, awready,
    input logic       wvalid, wready,
    input logic       arvalid, arready
);

    ////////////////////////////////////////////////////////////
    // Valid held until handshake
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr moved before handshake");

    assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid dropped or wdata moved before handshake");

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr moved before handshake");

    // Busy sequencer holds the pipe, stall only lets go as it returns to IDLE
    assert property (@(posedge clk) disable iff (rst)
        (state != IDLE) && !stall |=> (state == IDLE))
        else $error("stall released while a bus transaction stays open");

    assert property (@(posedge clk)
        rst |=> (state == IDLE) && !awvalid && !wvalid && !arvalid && !stall)
        else $error("bus or stall active right after reset");

endmodule

bind mem_unit mem_subsystem_asserts u_asserts (.*);

//--- test/mem_subsystem_tb.sv
// Loads only touch a 32-word window filled before the random mix; one op is sent at a time
`timescale 1ns/100ps

module mem_subsystem_tb import mem_pkg::*; ();

    localparam int    CLK_PERIOD     = 100;
    localparam int    N_DIRECTED     = 11;
    localparam int    WIN_WORDS      = 32;
    localparam word_t WIN_BASE       = 16'h0040;   // Random window, 0x40..0x7F
    localparam int    N_RANDOM       = 200;
    localparam int    N_OPS          = N_DIRECTED + WIN_WORDS + N_RANDOM;
    localparam int    TIMEOUT_CYCLES = N_OPS * (MEM_LATENCY + 4) + 30;

    typedef struct packed {
        logic     call;
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        logic     mem_to_reg;
        reg_idx_t reg_rd;
        word_t    alu;
        word_t    store_data;
        logic     ret_future;
        logic     halt;
    } op_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t reg_rd;
        word_t    data;
        logic     ret_future;
        logic     halted;
    } exp_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     ex_valid, call, reg_write, mem_write, mem_read, mem_to_reg;
    reg_idx_t reg_rd;
    word_t    alu_result, store_data;
    logic     ret_future, halt, stall;
    logic     wb_valid, wb_reg_write, wb_ret_future, halted;
    reg_idx_t wb_reg_rd;
    word_t    wb_data;

    word_t       ref_mem [MEM_WORDS];  // Reference copy of memory contents
    logic        ref_halted;
    logic [15:0] lfsr;
    exp_t        exp_q [$];            // Expected writebacks, in order
    longint      due_q [$];            // Time the compare process must see each

    mem_subsystem DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("Error: %s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input word_t got, input word_t want);
        $display("Fail %s: got %h, expected %h", name, got, want);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois, taps 16 14 13 11
    endfunction

    // One LFSR step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 16'h9E37) ^ 16'h5A5A;  // Every address bit matters
    endfunction

    function automatic op_t make_op(input logic c, rw, mw, mr, m2r, input reg_idx_t rd,
                                    input word_t alu, sd, input logic rf, h);
        return {c, rw, mw, mr, m2r, rd, alu, sd, rf, h};
    endfunction

    // Stage rules: ret reads 2 above, call passes alu minus 2
    function automatic exp_t ref_model(input op_t op);
        exp_t  e;
        word_t addr;
        word_t rd_word;
        addr    = op.ret_future ? op.alu + 16'd2 : op.alu;
        rd_word = ref_mem[addr[8:1]];  // Bit 0 ignored
        if (op.mem_write)
            ref_mem[addr[8:1]] = op.store_data;
        ref_halted   = ref_halted | op.halt;
        e.reg_write  = op.reg_write;
        e.reg_rd     = op.reg_rd;
        e.data       = op.mem_to_reg ? rd_word : (op.call ? op.alu - 16'd2 : op.alu);
        e.ret_future = op.ret_future;
        e.halted     = ref_halted;
        return e;
    endfunction

    // Called right after a rising edge, returns on the accepting edge
    task automatic send_op(input op_t op);
        int stalls;
        stalls = 0;
        ex_valid   <= 1'b1;
        call       <= op.call;
        reg_write  <= op.reg_write;
        mem_write  <= op.mem_write;
        mem_read   <= op.mem_read;
        mem_to_reg <= op.mem_to_reg;
        reg_rd     <= op.reg_rd;
        alu_result <= op.alu;
        store_data <= op.store_data;
        ret_future <= op.ret_future;
        halt       <= op.halt;
        @(negedge clk);
        while (stall) begin  // Inputs held meanwhile
            stalls++;
            @(negedge clk);
        end
        if (op.mem_write || op.mem_read)
            assert (stalls == MEM_LATENCY + 1)
                else abort_run($sformatf("memory op stalled %0d cycles", stalls));
        else
            assert (stalls == 0) else abort_run("operation without memory access stalled");
        exp_q.push_back(ref_model(op));
        due_q.push_back(longint'($time) + CLK_PERIOD * 3 / 2);  // One cycle after accept
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        ex_valid <= 1'b0;
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Comparison
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        exp_t   e;
        longint due;
        if (!rst && wb_valid) begin
            assert (exp_q.size() > 0) else abort_run("wb_valid with no operation outstanding");
            e   = exp_q.pop_front();
            due = due_q.pop_front();
            assert ($time == due) else abort_run("writeback not one cycle after acceptance");
            assert (wb_reg_write === e.reg_write)
                else value_mismatch("wb_reg_write", wb_reg_write, e.reg_write);
            assert (wb_reg_rd === e.reg_rd) else value_mismatch("wb_reg_rd", wb_reg_rd, e.reg_rd);
            assert (wb_data === e.data) else value_mismatch("wb_data", wb_data, e.data);
            assert (wb_ret_future === e.ret_future)
                else value_mismatch("wb_ret_future", wb_ret_future, e.ret_future);
            assert (halted === e.halted) else value_mismatch("halted", halted, e.halted);
        end
    end

    // Watchdog
    initial begin
        #(longint'(TIMEOUT_CYCLES) * CLK_PERIOD);
        $display("Timeout: operations did not retire within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        word_t    addr, off, data;
        logic     ret, rw, m2r;
        logic [1:0] kind;
        reg_idx_t rd;
        rst = 1'b1;
        ex_valid = 1'b0;
        call = 1'b0;
        reg_write = 1'b0;
        mem_write = 1'b0;
        mem_read = 1'b0;
        mem_to_reg = 1'b0;
        reg_rd = '0;
        alu_result = '0;
        store_data = '0;
        ret_future = 1'b0;
        halt = 1'b0;
        lfsr = 16'd58366;
        ref_halted = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!stall && !wb_valid && !wb_reg_write && !halted)
            else abort_run("outputs active after reset");
        @(posedge clk);
        // ALU only, back to back
        send_op(make_op(0, 1, 0, 0, 0, 4'd1, 16'h1234, 16'h0000, 0, 0));
        send_op(make_op(0, 1, 0, 0, 0, 4'd2, 16'hFFFF, 16'h0000, 0, 0));
        send_op(make_op(0, 0, 0, 0, 0, 4'd3, 16'h00A5, 16'h0000, 0, 0));
        idle_cycle();
        // Store, then loads from even and odd byte
        send_op(make_op(0, 0, 1, 0, 0, 4'd0, 16'h0050, 16'hC0DE, 0, 0));
        send_op(make_op(0, 1, 0, 1, 1, 4'd4, 16'h0050, 16'h0000, 0, 0));
        send_op(make_op(0, 1, 0, 1, 1, 4'd5, 16'h0051, 16'h0000, 0, 0));
        // Call pushes, load reads it back
        send_op(make_op(1, 1, 1, 0, 0, 4'd14, 16'h0060, 16'hBEEF, 0, 0));
        send_op(make_op(0, 1, 0, 1, 1, 4'd6, 16'h0060, 16'h0000, 0, 0));
        // Ret reads 2 above, with and without mem_to_reg
        send_op(make_op(0, 1, 0, 1, 1, 4'd7, 16'h005E, 16'h0000, 1, 0));
        send_op(make_op(0, 1, 0, 1, 0, 4'd8, 16'h005E, 16'h0000, 1, 0));
        send_op(make_op(0, 0, 0, 0, 0, 4'd0, 16'h0000, 16'h0000, 0, 1));  // Halt
        for (int i = 0; i < WIN_WORDS; i++) begin
            addr = WIN_BASE + word_t'(2 * i);
            send_op(make_op(0, 0, 1, 0, 0, 4'd0, addr, fill_word(addr), 0, 0));
        end
        // Random mix
        for (int i = 0; i < N_RANDOM; i++) begin
            kind = 2'(rand_bits(2));
            ret  = 1'(rand_bits(1));
            off  = rand_bits(5);
            if (ret && off == 16'd31)
                off = 16'd30;  // Keep alu plus 2 inside window
            addr = WIN_BASE + (off << 1) + rand_bits(1);
            rw   = 1'(rand_bits(1));
            m2r  = 1'(rand_bits(1));
            rd   = reg_idx_t'(rand_bits(4));
            data = rand_bits(16);
            case (kind)
                2'd0: send_op(make_op(0, rw, 0, 0, 0, rd, data, 16'h0000, ret, 0));
                2'd1: send_op(make_op(0, 0, 1, 0, 0, rd, addr, data, ret, 0));
                2'd2: send_op(make_op(0, rw, 0, 1, m2r, rd, addr, 16'h0000, ret, 0));
                default: send_op(make_op(1, 1, 1, 0, 0, rd, addr, data, 0, 0));
            endcase
            if (rand_bits(1))
                idle_cycle();
        end
        ex_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);  // Late extra writebacks trip the compare process
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- all.f
rtl/mem_pkg.sv
rtl/mem_unit.sv
rtl/data_memory.sv
rtl/mem_wb_stage.sv
rtl/mem_subsystem.sv
test/mem_subsystem_asserts.sv
test/mem_subsystem_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - rtl/mem_pkg.sv
      - rtl/mem_unit.sv
      - rtl/data_memory.sv
      - rtl/mem_wb_stage.sv
      - rtl/mem_subsystem.sv
  - target: test
    files:
      - test/mem_subsystem_asserts.sv
      - test/mem_subsystem_tb.sv
